//--- test/tb_bus_tasks.svh
// ####################
// host side bus tasks drive 1 unit after posedge
// every task returns 1 unit after a rising edge
// ####################

`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual) begin
    $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
    $display("Finished with errors");
    $fatal(1, "stopped at first failing check");
  end
endtask

// one full transaction
// hold is the number of cycles d_ready stays low
task automatic bus_access(input logic write, input soc_pkg::bus_addr_t addr,
                          input soc_pkg::bus_data_t wdata, input soc_pkg::bus_mask_t mask,
                          input int hold, output soc_pkg::bus_data_t rdata,
                          output logic err);
  logic               done;
  int                 waited;
  soc_pkg::bus_data_t first_data;
  logic               first_err;
  host_a_valid = 1'b1;
  host_a_write = write;
  host_a_addr  = addr;
  host_a_wdata = wdata;
  host_a_mask  = mask;
  host_d_ready = (hold == 0);
  done = 1'b0;
  while (!done) begin
    @(negedge clk);
    done = host_a_ready;
    @(posedge clk);
    #1;
  end
  last_accept  = cycle;
  host_a_valid = 1'b0;

  // response is due right after the acceptance edge
  @(negedge clk);
  check_value("response latency", 1, host_d_valid);
  first_data = host_d_data;
  first_err  = host_d_error;
  waited = 0;
  done = 1'b0;
  while (!done) begin
    check_value("response valid held", 1, host_d_valid);
    check_value("response data held", first_data, host_d_data);
    check_value("response error held", first_err, host_d_error);
    check_value("a_ready while busy", 0, host_a_ready);
    done = host_d_ready;
    @(posedge clk);
    #1;
    waited++;
    if (waited >= hold) host_d_ready = 1'b1;
    if (!done) @(negedge clk);
  end
  rdata = first_data;
  err   = first_err;
endtask

task automatic bus_write(input soc_pkg::bus_addr_t addr, input soc_pkg::bus_data_t wdata,
                         input soc_pkg::bus_mask_t mask);
  soc_pkg::bus_data_t rdata;
  logic               err;
  bus_access(1'b1, addr, wdata, mask, 0, rdata, err);
  check_value("write error flag", 0, err);
endtask

task automatic bus_read(input string name, input soc_pkg::bus_addr_t addr,
                        output soc_pkg::bus_data_t rdata);
  logic err;
  bus_access(1'b0, addr, '0, 4'hf, 0, rdata, err);
  check_value({name, " error flag"}, 0, err);
endtask

`endif

//--- test/tb_top_soc.sv
// ####################
// random testbench with ram, gpio and timer models
// ram is prefilled first since its contents are not reset
// ####################

`include "soc_consts.svh"

module tb_top_soc;

  localparam int TimeoutCycles = 4000;
  localparam soc_pkg::bus_addr_t RamBase    = `SOC_RAM_BASE;
  localparam soc_pkg::bus_addr_t GpioIn     = `SOC_GPIO_BASE + 32'h0;
  localparam soc_pkg::bus_addr_t GpioOut    = `SOC_GPIO_BASE + 32'h4;
  localparam soc_pkg::bus_addr_t GpioOe     = `SOC_GPIO_BASE + 32'h8;
  localparam soc_pkg::bus_addr_t GpioState  = `SOC_GPIO_BASE + 32'hc;
  localparam soc_pkg::bus_addr_t GpioEnable = `SOC_GPIO_BASE + 32'h10;
  localparam soc_pkg::bus_addr_t TimerMtime = `SOC_TIMER_BASE + 32'h0;
  localparam soc_pkg::bus_addr_t TimerCmp   = `SOC_TIMER_BASE + 32'h4;
  localparam soc_pkg::bus_addr_t TimerCtrl  = `SOC_TIMER_BASE + 32'h8;

  logic                   clk;
  logic                   reset;
  logic                   host_a_valid;
  logic                   host_a_write;
  soc_pkg::bus_addr_t     host_a_addr;
  soc_pkg::bus_data_t     host_a_wdata;
  soc_pkg::bus_mask_t     host_a_mask;
  logic                   host_a_ready;
  logic                   host_d_valid;
  soc_pkg::bus_data_t     host_d_data;
  logic                   host_d_error;
  logic                   host_d_ready;
  logic [`SOC_GPIO_W-1:0] gpio_in;
  logic [`SOC_GPIO_W-1:0] gpio_out;
  logic [`SOC_GPIO_W-1:0] gpio_oe;
  logic                   intr_gpio;
  logic                   intr_timer;

  int     cycle = 0;
  int     last_accept;
  integer seed;

  // reference model state
  soc_pkg::bus_data_t     ram_model [256];
  logic [`SOC_GPIO_W-1:0] out_model;
  logic [`SOC_GPIO_W-1:0] oe_model;
  logic [`SOC_GPIO_W-1:0] en_model;
  logic [`SOC_GPIO_W-1:0] state_model;
  logic [`SOC_GPIO_W-1:0] pins;
  int                     ctrl_on;

  top_soc dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .host_a_valid_i (host_a_valid),
    .host_a_write_i (host_a_write),
    .host_a_addr_i  (host_a_addr),
    .host_a_wdata_i (host_a_wdata),
    .host_a_mask_i  (host_a_mask),
    .host_a_ready_o (host_a_ready),
    .host_d_valid_o (host_d_valid),
    .host_d_data_o  (host_d_data),
    .host_d_error_o (host_d_error),
    .host_d_ready_i (host_d_ready),
    .gpio_i         (gpio_in),
    .gpio_o         (gpio_out),
    .gpio_oe_o      (gpio_oe),
    .intr_gpio_o    (intr_gpio),
    .intr_timer_o   (intr_timer)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TimeoutCycles) begin
      $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Finished with errors");
      $fatal(1, "stopped by timeout");
    end
  end

  `include "tb_bus_tasks.svh"

  function automatic soc_pkg::bus_addr_t ram_addr(int word);
    return RamBase + (word << 2);
  endfunction

  function automatic soc_pkg::bus_data_t apply_mask(soc_pkg::bus_data_t old_word,
                                                    soc_pkg::bus_data_t new_word,
                                                    soc_pkg::bus_mask_t mask);
    soc_pkg::bus_data_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  task automatic ram_random_traffic();
    soc_pkg::bus_data_t rdata;
    soc_pkg::bus_data_t wdata;
    soc_pkg::bus_mask_t mask;
    int                 word;
    for (int i = 0; i < 256; i++) begin
      wdata = $random(seed);
      bus_write(ram_addr(i), wdata, 4'hf);
      ram_model[i] = wdata;
    end
    for (int n = 0; n < 200; n++) begin
      word  = $unsigned($random(seed)) % 256;
      wdata = $random(seed);
      mask  = $random(seed);
      bus_write(ram_addr(word), wdata, mask);
      ram_model[word] = apply_mask(ram_model[word], wdata, mask);
      word = $unsigned($random(seed)) % 256;
      bus_read("ram read", ram_addr(word), rdata);
      check_value("ram read", ram_model[word], rdata);
    end
  endtask

  task automatic gpio_pin_paths();
    soc_pkg::bus_data_t rdata;
    for (int n = 0; n < 16; n++) begin
      out_model = $random(seed);
      oe_model  = $random(seed);
      // registers take the full word whatever the byte mask
      bus_write(GpioOut, 32'(out_model), 4'($random(seed)));
      bus_write(GpioOe, 32'(oe_model), 4'($random(seed)));
      @(negedge clk);
      check_value("gpio_o", 32'(out_model), 32'(gpio_out));
      check_value("gpio_oe_o", 32'(oe_model), 32'(gpio_oe));
      @(posedge clk);
      #1;
      bus_read("DIRECT_OUT readback", GpioOut, rdata);
      check_value("DIRECT_OUT readback", 32'(out_model), rdata);
      bus_read("DIRECT_OE readback", GpioOe, rdata);
      check_value("DIRECT_OE readback", 32'(oe_model), rdata);
    end
    for (int n = 0; n < 16; n++) begin
      pins    = $random(seed);
      gpio_in = pins;
      repeat (3) @(posedge clk);
      #1;
      bus_read("DATA_IN", GpioIn, rdata);
      check_value("DATA_IN", 32'(pins), rdata);
    end
  endtask

  task automatic gpio_edge_interrupts();
    soc_pkg::bus_data_t     rdata;
    logic [`SOC_GPIO_W-1:0] new_pins;
    logic [`SOC_GPIO_W-1:0] clr_bit;
    bus_write(GpioState, 32'hffff, 4'hf);
    state_model = '0;
    en_model    = $random(seed);
    bus_write(GpioEnable, 32'(en_model), 4'hf);
    bus_read("INTR_STATE cleared", GpioState, rdata);
    check_value("INTR_STATE cleared", 0, rdata);
    for (int n = 0; n < 16; n++) begin
      new_pins = $random(seed);
      // only low to high transitions count
      state_model = state_model | (new_pins & ~pins);
      pins    = new_pins;
      gpio_in = pins;
      repeat (3) @(posedge clk);
      #1;
      bus_read("INTR_STATE after edges", GpioState, rdata);
      check_value("INTR_STATE after edges", 32'(state_model), rdata);
      @(negedge clk);
      check_value("intr_gpio_o", |(state_model & en_model), intr_gpio);
      @(posedge clk);
      #1;
      clr_bit = 1 << ($unsigned($random(seed)) % `SOC_GPIO_W);
      bus_write(GpioState, 32'(clr_bit), 4'hf);
      state_model = state_model & ~clr_bit;
      bus_read("INTR_STATE after clear", GpioState, rdata);
      check_value("INTR_STATE after clear", 32'(state_model), rdata);
      check_value("intr_gpio_o after clear", |(state_model & en_model), intr_gpio);
    end
  endtask

  task automatic timer_count_and_expiry();
    soc_pkg::bus_data_t d1;
    soc_pkg::bus_data_t d2;
    int                 c1;
    int                 target;
    bus_write(TimerCtrl, 32'h1, 4'hf);
    ctrl_on = last_accept;
    repeat (3 + $unsigned($random(seed)) % 8) @(posedge clk);
    #1;
    // counting starts on the edge after the enabling write
    bus_read("MTIME first", TimerMtime, d1);
    c1 = last_accept;
    check_value("MTIME first", c1 - ctrl_on - 1, d1);
    repeat (1 + $unsigned($random(seed)) % 12) @(posedge clk);
    #1;
    bus_read("MTIME second", TimerMtime, d2);
    check_value("MTIME delta", last_accept - c1, d2 - d1);
    target = cycle - ctrl_on + 30;
    bus_write(TimerCmp, target, 4'hf);
    repeat (50) begin
      @(negedge clk);
      check_value("intr_timer_o", (cycle - ctrl_on) >= target, intr_timer);
    end
    @(posedge clk);
    #1;
    bus_write(TimerCtrl, 32'h0, 4'hf);
    @(negedge clk);
    check_value("intr_timer_o after stop", 0, intr_timer);
    @(posedge clk);
    #1;
  endtask

  task automatic unmapped_access_error();
    soc_pkg::bus_data_t rdata;
    logic               err;
    int                 word;
    bus_access(1'b0, 32'h2000_0000, '0, 4'hf, 0, rdata, err);
    check_value("unmapped read error", 1, err);
    check_value("unmapped read data", 0, rdata);
    bus_access(1'b1, 32'h4004_0010, 32'h1234_5678, 4'hf, 2, rdata, err);
    check_value("unmapped write error", 1, err);
    check_value("unmapped write data", 0, rdata);
    word = $unsigned($random(seed)) % 256;
    bus_read("ram after unmapped", ram_addr(word), rdata);
    check_value("ram after unmapped", ram_model[word], rdata);
  endtask

  task automatic stalled_responses();
    soc_pkg::bus_data_t rdata;
    soc_pkg::bus_data_t wdata;
    soc_pkg::bus_mask_t mask;
    logic               err;
    int                 word;
    for (int n = 0; n < 20; n++) begin
      word  = $unsigned($random(seed)) % 256;
      wdata = $random(seed);
      mask  = $random(seed);
      bus_access(1'b1, ram_addr(word), wdata, mask, 1 + $unsigned($random(seed)) % 8,
                 rdata, err);
      check_value("stalled write error", 0, err);
      ram_model[word] = apply_mask(ram_model[word], wdata, mask);
      word = $unsigned($random(seed)) % 256;
      bus_access(1'b0, ram_addr(word), '0, 4'hf, 1 + $unsigned($random(seed)) % 8,
                 rdata, err);
      check_value("stalled read error", 0, err);
      check_value("stalled read data", ram_model[word], rdata);
    end
  endtask

  initial begin
    seed         = 32'hf602_2625;
    reset        = 1'b1;
    host_a_valid = 1'b0;
    host_a_write = 1'b0;
    host_a_addr  = '0;
    host_a_wdata = '0;
    host_a_mask  = '0;
    host_d_ready = 1'b1;
    gpio_in      = '0;
    pins         = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_value("a_ready after reset", 1, host_a_ready);
    check_value("d_valid after reset", 0, host_d_valid);
    check_value("intr_gpio_o after reset", 0, intr_gpio);
    check_value("intr_timer_o after reset", 0, intr_timer);
    check_value("gpio_o after reset", 0, 32'(gpio_out));
    check_value("gpio_oe_o after reset", 0, 32'(gpio_oe));
    @(posedge clk);
    #1;
    ram_random_traffic();
    gpio_pin_paths();
    gpio_edge_interrupts();
    timer_count_and_expiry();
    unmapped_access_error();
    stalled_responses();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- top_soc.f
+incdir+verilog
+incdir+test
verilog/soc_pkg.sv
verilog/tl_if.sv
verilog/xbar_main.sv
verilog/ram_main.sv
verilog/gpio.sv
verilog/rv_timer.sv
verilog/top_soc.sv
test/tb_top_soc.sv

//--- verilog/gpio.sv
// ####################
// gpio with direct out/oe, 2-flop input sync, rising edge irq
// register writes ignore the byte mask
// ####################

`include "soc_consts.svh"

module gpio (
  input  logic                   clk_i,
  input  logic                   reset_i,
  tl_if.device                   bus,
  input  logic [`SOC_GPIO_W-1:0] gpio_i,
  output logic [`SOC_GPIO_W-1:0] gpio_o,
  output logic [`SOC_GPIO_W-1:0] gpio_oe_o,
  output logic                   intr_o
);

  localparam logic [`SOC_DEV_WINDOW_AW-1:0] OffDataIn     = 'h0;
  localparam logic [`SOC_DEV_WINDOW_AW-1:0] OffDirectOut  = 'h4;
  localparam logic [`SOC_DEV_WINDOW_AW-1:0] OffDirectOe   = 'h8;
  localparam logic [`SOC_DEV_WINDOW_AW-1:0] OffIntrState  = 'hc;
  localparam logic [`SOC_DEV_WINDOW_AW-1:0] OffIntrEnable = 'h10;

  logic [`SOC_DEV_WINDOW_AW-1:0] offset;
  logic                          accept;
  logic                          wr;
  logic [`SOC_GPIO_W-1:0]        wdata;
  logic [`SOC_GPIO_W-1:0]        sync1_q, sync2_q, prev_q;
  logic [`SOC_GPIO_W-1:0]        rise, clr;
  logic [`SOC_GPIO_W-1:0]        out_q, oe_q, state_q, enable_q;
  soc_pkg::bus_data_t            rdata;
  logic                          rsp_valid_q;
  soc_pkg::bus_data_t            rsp_data_q;

  assign offset      = bus.a_addr[`SOC_DEV_WINDOW_AW-1:0];
  assign bus.a_ready = !rsp_valid_q;
  assign accept      = bus.a_valid && bus.a_ready;
  assign wr          = accept && bus.a_write;
  assign wdata       = bus.a_wdata[`SOC_GPIO_W-1:0];

  // input synchronizer, prev_q feeds the edge detect
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise = sync2_q & ~prev_q;
  assign clr  = (wr && offset == OffIntrState) ? wdata : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q    <= '0;
      oe_q     <= '0;
      enable_q <= '0;
      state_q  <= '0;
    end else begin
      if (wr && offset == OffDirectOut) out_q <= wdata;
      if (wr && offset == OffDirectOe) oe_q <= wdata;
      if (wr && offset == OffIntrEnable) enable_q <= wdata;
      // a new edge beats a clear in the same cycle
      state_q <= (state_q & ~clr) | rise;
    end
  end

  always_comb begin
    case (offset)
      OffDataIn:     rdata = soc_pkg::bus_data_t'(sync2_q);
      OffDirectOut:  rdata = soc_pkg::bus_data_t'(out_q);
      OffDirectOe:   rdata = soc_pkg::bus_data_t'(oe_q);
      OffIntrState:  rdata = soc_pkg::bus_data_t'(state_q);
      OffIntrEnable: rdata = soc_pkg::bus_data_t'(enable_q);
      default:       rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (bus.d_valid && bus.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) rsp_data_q <= bus.a_write ? '0 : rdata;
  end

  assign bus.d_valid = rsp_valid_q;
  assign bus.d_data  = rsp_data_q;
  assign bus.d_error = 1'b0;

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign intr_o    = |(state_q & enable_q);

endmodule

//--- verilog/ram_main.sv
// ####################
// 256 word ram behind the bus, byte masked writes
// contents are undefined after reset
// ####################

`include "soc_consts.svh"

module ram_main (
  input  logic clk_i,
  input  logic reset_i,
  tl_if.device bus
);

  localparam int Depth = 1 << `SOC_RAM_AW;

  soc_pkg::bus_data_t   mem [Depth];
  logic [`SOC_RAM_AW-1:0] word_addr;
  logic                 accept;
  logic                 rsp_valid_q;
  logic                 rsp_read_q;
  soc_pkg::bus_data_t   rdata_q;

  // word address, byte offset bits ignored
  assign word_addr = bus.a_addr[`SOC_RAM_AW+1:2];

  // one response at a time
  assign bus.a_ready = !rsp_valid_q;
  assign accept      = bus.a_valid && bus.a_ready;

  // storage port
  always_ff @(posedge clk_i) begin
    if (accept && bus.a_write) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.a_mask[i]) begin
          mem[word_addr][8*i +: 8] <= bus.a_wdata[8*i +: 8];
        end
      end
    end
    if (accept && !bus.a_write) begin
      rdata_q <= mem[word_addr];
    end
  end

  // response holds until the host takes it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
      rsp_read_q  <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
      rsp_read_q  <= !bus.a_write;
    end else if (bus.d_valid && bus.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign bus.d_valid = rsp_valid_q;
  // writes answer with zero data
  assign bus.d_data  = rsp_read_q ? rdata_q : '0;
  assign bus.d_error = 1'b0;

endmodule

//--- verilog/rv_timer.sv
// ####################
// 32-bit mtime with one compare, counts while CTRL[0] is set
// register writes ignore the byte mask
// ####################

`include "soc_consts.svh"

module rv_timer (
  input  logic clk_i,
  input  logic reset_i,
  tl_if.device bus,
  output logic intr_o
);

  localparam logic [`SOC_DEV_WINDOW_AW-1:0] OffMtime    = 'h0;
  localparam logic [`SOC_DEV_WINDOW_AW-1:0] OffMtimecmp = 'h4;
  localparam logic [`SOC_DEV_WINDOW_AW-1:0] OffCtrl     = 'h8;

  logic [`SOC_DEV_WINDOW_AW-1:0] offset;
  logic                          accept;
  logic                          wr;
  soc_pkg::bus_data_t            mtime_q;
  soc_pkg::bus_data_t            mtimecmp_q;
  logic                          enable_q;
  soc_pkg::bus_data_t            rdata;
  logic                          rsp_valid_q;
  soc_pkg::bus_data_t            rsp_data_q;

  assign offset      = bus.a_addr[`SOC_DEV_WINDOW_AW-1:0];
  assign bus.a_ready = !rsp_valid_q;
  assign accept      = bus.a_valid && bus.a_ready;
  assign wr          = accept && bus.a_write;

  // a bus write to MTIME wins over the increment
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime_q <= '0;
    end else if (wr && offset == OffMtime) begin
      mtime_q <= bus.a_wdata;
    end else if (enable_q) begin
      mtime_q <= mtime_q + 32'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtimecmp_q <= '1;
      enable_q   <= 1'b0;
    end else begin
      if (wr && offset == OffMtimecmp) mtimecmp_q <= bus.a_wdata;
      if (wr && offset == OffCtrl) enable_q <= bus.a_wdata[0];
    end
  end

  // reads see the count before the acceptance edge
  always_comb begin
    case (offset)
      OffMtime:    rdata = mtime_q;
      OffMtimecmp: rdata = mtimecmp_q;
      OffCtrl:     rdata = {31'b0, enable_q};
      default:     rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (bus.d_valid && bus.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) rsp_data_q <= bus.a_write ? '0 : rdata;
  end

  assign bus.d_valid = rsp_valid_q;
  assign bus.d_data  = rsp_data_q;
  assign bus.d_error = 1'b0;

  // expiry only counts while the timer runs
  assign intr_o = enable_q && (mtime_q >= mtimecmp_q);

endmodule

//--- verilog/soc_consts.svh
// ####################
// address map and sizes of the subsystem
// each device window is 4 KiB and aligned to its size
// ####################

`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// device base addresses
`define SOC_RAM_BASE   32'h1000_0000
`define SOC_GPIO_BASE  32'h4000_0000
`define SOC_TIMER_BASE 32'h4008_0000

// low address bits decoded inside a device window
`define SOC_DEV_WINDOW_AW 12

// ram word address width, 256 words
`define SOC_RAM_AW 8

// number of gpio pins
`define SOC_GPIO_W 16

`endif

//--- verilog/soc_pkg.sv
// ####################
// bus word types shared by the crossbar and all devices
// data bus is fixed at 32 bits with one mask bit per byte
// ####################

package soc_pkg;

  // byte address as seen by the host
  typedef logic [31:0] bus_addr_t;

  // one bus data word
  typedef logic [31:0] bus_data_t;

  // byte enables, bit i covers data bits [8*i+7:8*i]
  typedef logic [3:0] bus_mask_t;

  // decoded target of a request
  // DevNone means no device window matched and the
  // crossbar answers with an error itself
  typedef enum logic [1:0] {
    DevRam   = 2'd0,
    DevGpio  = 2'd1,
    DevTimer = 2'd2,
    DevNone  = 2'd3
  } dev_sel_e;

endpackage

//--- verilog/tl_if.sv
// ####################
// request/response bus, one transaction per handshake
// fields hold steady while valid waits for ready
// ####################

interface tl_if;

  // request channel, driven by the host
  logic                  a_valid;
  logic                  a_write;
  soc_pkg::bus_addr_t    a_addr;
  soc_pkg::bus_data_t    a_wdata;
  soc_pkg::bus_mask_t    a_mask;
  logic                  a_ready;

  // response channel, driven by the device
  logic                  d_valid;
  soc_pkg::bus_data_t    d_data;
  logic                  d_error;
  logic                  d_ready;

  modport host (
    output a_valid, a_write, a_addr, a_wdata, a_mask, d_ready,
    input  a_ready, d_valid, d_data, d_error
  );

  modport device (
    input  a_valid, a_write, a_addr, a_wdata, a_mask, d_ready,
    output a_ready, d_valid, d_data, d_error
  );

endinterface

//--- verilog/top_soc.sv
// ####################
// host port -> crossbar -> ram, gpio, timer
// single clock and a single synchronous reset
// ####################

`include "soc_consts.svh"

module top_soc (
  input  logic                   clk_i,
  input  logic                   reset_i,

  // host request
  input  logic                   host_a_valid_i,
  input  logic                   host_a_write_i,
  input  soc_pkg::bus_addr_t     host_a_addr_i,
  input  soc_pkg::bus_data_t     host_a_wdata_i,
  input  soc_pkg::bus_mask_t     host_a_mask_i,
  output logic                   host_a_ready_o,

  // host response
  output logic                   host_d_valid_o,
  output soc_pkg::bus_data_t     host_d_data_o,
  output logic                   host_d_error_o,
  input  logic                   host_d_ready_i,

  // pins and interrupts
  input  logic [`SOC_GPIO_W-1:0] gpio_i,
  output logic [`SOC_GPIO_W-1:0] gpio_o,
  output logic [`SOC_GPIO_W-1:0] gpio_oe_o,
  output logic                   intr_gpio_o,
  output logic                   intr_timer_o
);

  tl_if host_bus ();
  tl_if ram_bus ();
  tl_if gpio_bus ();
  tl_if timer_bus ();

  // plain host ports onto the crossbar bus
  assign host_bus.a_valid = host_a_valid_i;
  assign host_bus.a_write = host_a_write_i;
  assign host_bus.a_addr  = host_a_addr_i;
  assign host_bus.a_wdata = host_a_wdata_i;
  assign host_bus.a_mask  = host_a_mask_i;
  assign host_bus.d_ready = host_d_ready_i;
  assign host_a_ready_o   = host_bus.a_ready;
  assign host_d_valid_o   = host_bus.d_valid;
  assign host_d_data_o    = host_bus.d_data;
  assign host_d_error_o   = host_bus.d_error;

  xbar_main u_xbar_main (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .host_bus  (host_bus),
    .ram_bus   (ram_bus),
    .gpio_bus  (gpio_bus),
    .timer_bus (timer_bus)
  );

  ram_main u_ram_main (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (ram_bus)
  );

  gpio u_gpio (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .bus       (gpio_bus),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .intr_o    (intr_gpio_o)
  );

  rv_timer u_rv_timer (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (timer_bus),
    .intr_o  (intr_timer_o)
  );

endmodule

//--- verilog/xbar_main.sv
// ####################
// one host to three devices, one transaction in flight
// unmapped addresses get an error response with zero data
// ####################

`include "soc_consts.svh"

module xbar_main (
  input  logic clk_i,
  input  logic reset_i,
  tl_if.device host_bus,
  tl_if.host   ram_bus,
  tl_if.host   gpio_bus,
  tl_if.host   timer_bus
);

  localparam soc_pkg::bus_addr_t RamBase   = `SOC_RAM_BASE;
  localparam soc_pkg::bus_addr_t GpioBase  = `SOC_GPIO_BASE;
  localparam soc_pkg::bus_addr_t TimerBase = `SOC_TIMER_BASE;

  soc_pkg::dev_sel_e req_sel;
  soc_pkg::dev_sel_e sel_q;
  logic              busy_q;
  logic              req_fire;
  logic              rsp_fire;

  // upper address bits must match a base exactly
  function automatic soc_pkg::dev_sel_e decode(soc_pkg::bus_addr_t addr);
    if (addr[31:`SOC_DEV_WINDOW_AW] == RamBase[31:`SOC_DEV_WINDOW_AW]) begin
      return soc_pkg::DevRam;
    end
    if (addr[31:`SOC_DEV_WINDOW_AW] == GpioBase[31:`SOC_DEV_WINDOW_AW]) begin
      return soc_pkg::DevGpio;
    end
    if (addr[31:`SOC_DEV_WINDOW_AW] == TimerBase[31:`SOC_DEV_WINDOW_AW]) begin
      return soc_pkg::DevTimer;
    end
    return soc_pkg::DevNone;
  endfunction

  assign req_sel  = decode(host_bus.a_addr);
  assign req_fire = host_bus.a_valid && host_bus.a_ready;
  assign rsp_fire = host_bus.d_valid && host_bus.d_ready;

  // valid only reaches the selected device, fields go everywhere
  assign ram_bus.a_valid   = host_bus.a_valid && !busy_q && (req_sel == soc_pkg::DevRam);
  assign gpio_bus.a_valid  = host_bus.a_valid && !busy_q && (req_sel == soc_pkg::DevGpio);
  assign timer_bus.a_valid = host_bus.a_valid && !busy_q && (req_sel == soc_pkg::DevTimer);

  assign ram_bus.a_write   = host_bus.a_write;
  assign ram_bus.a_addr    = host_bus.a_addr;
  assign ram_bus.a_wdata   = host_bus.a_wdata;
  assign ram_bus.a_mask    = host_bus.a_mask;
  assign gpio_bus.a_write  = host_bus.a_write;
  assign gpio_bus.a_addr   = host_bus.a_addr;
  assign gpio_bus.a_wdata  = host_bus.a_wdata;
  assign gpio_bus.a_mask   = host_bus.a_mask;
  assign timer_bus.a_write = host_bus.a_write;
  assign timer_bus.a_addr  = host_bus.a_addr;
  assign timer_bus.a_wdata = host_bus.a_wdata;
  assign timer_bus.a_mask  = host_bus.a_mask;

  always_comb begin
    case (req_sel)
      soc_pkg::DevRam:   host_bus.a_ready = !busy_q && ram_bus.a_ready;
      soc_pkg::DevGpio:  host_bus.a_ready = !busy_q && gpio_bus.a_ready;
      soc_pkg::DevTimer: host_bus.a_ready = !busy_q && timer_bus.a_ready;
      default:           host_bus.a_ready = !busy_q;
    endcase
  end

  // response comes from the device latched at acceptance
  always_comb begin
    host_bus.d_valid = 1'b0;
    host_bus.d_data  = '0;
    host_bus.d_error = 1'b0;
    if (busy_q) begin
      case (sel_q)
        soc_pkg::DevRam: begin
          host_bus.d_valid = ram_bus.d_valid;
          host_bus.d_data  = ram_bus.d_data;
          host_bus.d_error = ram_bus.d_error;
        end
        soc_pkg::DevGpio: begin
          host_bus.d_valid = gpio_bus.d_valid;
          host_bus.d_data  = gpio_bus.d_data;
          host_bus.d_error = gpio_bus.d_error;
        end
        soc_pkg::DevTimer: begin
          host_bus.d_valid = timer_bus.d_valid;
          host_bus.d_data  = timer_bus.d_data;
          host_bus.d_error = timer_bus.d_error;
        end
        default: begin
          // own error answer, one cycle after acceptance
          host_bus.d_valid = 1'b1;
          host_bus.d_error = 1'b1;
        end
      endcase
    end
  end

  assign ram_bus.d_ready   = host_bus.d_ready && busy_q && (sel_q == soc_pkg::DevRam);
  assign gpio_bus.d_ready  = host_bus.d_ready && busy_q && (sel_q == soc_pkg::DevGpio);
  assign timer_bus.d_ready = host_bus.d_ready && busy_q && (sel_q == soc_pkg::DevTimer);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      sel_q  <= soc_pkg::DevNone;
    end else if (req_fire) begin
      busy_q <= 1'b1;
      sel_q  <= req_sel;
    end else if (rsp_fire) begin
      busy_q <= 1'b0;
    end
  end

endmodule
